// File: hw/store_buffer_pkg.sv
package store_buffer_pkg;

  // physical address and data widths
  localparam int unsigned PLEN = 34;
  localparam int unsigned XLEN = 64;

  // cache index covers the page offset
  // tag is everything above it
  localparam int unsigned DCACHE_INDEX_WIDTH = 12;
  localparam int unsigned DCACHE_TAG_WIDTH   = 22;

  // --------------------
  // plain vector types
  // --------------------
  typedef logic [PLEN-1:0]               paddr_t;
  typedef logic [XLEN-1:0]               data_t;
  typedef logic [(XLEN/8)-1:0]           be_t;
  // encoded access size
  typedef logic [1:0]                    size_t;
  // offset inside a 4 KiB page
  typedef logic [11:0]                   page_offset_t;
  // 8-byte word inside the page, address bits 11 to 3
  typedef logic [8:0]                    word_offset_t;
  typedef logic [DCACHE_INDEX_WIDTH-1:0] dc_index_t;
  typedef logic [DCACHE_TAG_WIDTH-1:0]   dc_tag_t;

  // --------------------
  // bundles
  // --------------------
  // one buffered store, same layout in both queues
  typedef struct packed {
    paddr_t address;
    data_t  data;
    be_t    be;
    size_t  data_size;
  } store_entry_t;

  // write request towards the data cache
  typedef struct packed {
    logic      data_req;
    dc_index_t address_index;
    dc_tag_t   address_tag;
    data_t     data_wdata;
    be_t       data_be;
    size_t     data_size;
  } dcache_wreq_t;

endpackage

// File: hw/spec_queue.sv
`timescale 1ns/1ps

module spec_queue #(
  // must be a power of two, at least 2
  parameter int unsigned DEPTH_SPEC = 4
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  input  logic                                         valid_i,
  input  logic                                         commit_i,
  input  store_buffer_pkg::store_entry_t               entry_i,
  output logic                                         ready_o,
  output logic                                         empty_o,
  output store_buffer_pkg::store_entry_t               head_o,
  output logic [DEPTH_SPEC-1:0]                        slot_valid_o,
  output store_buffer_pkg::word_offset_t [DEPTH_SPEC-1:0] slot_offset_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH_SPEC);
  // one extra bit so a full queue is representable
  localparam int unsigned CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH_SPEC);

  // store payload
  store_buffer_pkg::store_entry_t mem_q [DEPTH_SPEC];

  // per-slot valid bits for the address checker
  logic [DEPTH_SPEC-1:0] valid_q, valid_d;

  logic [PTR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [PTR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;

  // --------------------
  // next-state logic
  // --------------------
  always_comb begin
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    valid_d  = valid_q;

    // commit hands the head to the commit queue
    // invalidate first so a push into the same slot survives when full
    if (commit_i) begin
      valid_d[rd_ptr_q] = 1'b0;
      rd_ptr_d          = rd_ptr_q + PTR_W'(1);
    end

    // new store lands at the write pointer
    if (valid_i) begin
      valid_d[wr_ptr_q] = 1'b1;
      wr_ptr_d          = wr_ptr_q + PTR_W'(1);
    end

    // status count follows push and commit
    case ({valid_i, commit_i})
      2'b10:   cnt_d = cnt_q + CNT_W'(1);
      2'b01:   cnt_d = cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase

    // flush drops every speculative store
    // write pointer falls back onto the read pointer
    if (flush_i) begin
      valid_d  = '0;
      wr_ptr_d = rd_ptr_q;
      cnt_d    = '0;
    end
  end

  // room for another store after this cycle, or a slot frees by commit
  assign ready_o = (cnt_d < CNT_MAX) || commit_i;
  assign empty_o = (cnt_q == '0);

  // oldest store, read by the commit queue
  assign head_o = mem_q[rd_ptr_q];

  // --------------------
  // checker taps
  // --------------------
  assign slot_valid_o = valid_q;

  for (genvar i = 0; i < DEPTH_SPEC; i++) begin : g_slot
    // word within the page
    assign slot_offset_o[i] = mem_q[i].address[11:3];
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // payload storage, qualified by valid_q
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

// File: hw/commit_queue.sv
`timescale 1ns/1ps

module commit_queue #(
  // must be a power of two, at least 2
  parameter int unsigned DEPTH_COMMIT = 4
) (
  input  logic                                           clk_i,
  input  logic                                           rst_ni,
  input  logic                                           stall_st_pending_i,
  input  logic                                           commit_i,
  input  logic                                           data_gnt_i,
  input  store_buffer_pkg::store_entry_t                 entry_i,
  output logic                                           commit_ready_o,
  output logic                                           no_st_pending_o,
  output store_buffer_pkg::dcache_wreq_t                 dcache_wreq_o,
  output logic [DEPTH_COMMIT-1:0]                        slot_valid_o,
  output store_buffer_pkg::word_offset_t [DEPTH_COMMIT-1:0] slot_offset_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH_COMMIT);
  localparam int unsigned CNT_W = PTR_W + 1;
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(DEPTH_COMMIT);

  // committed stores waiting for the cache
  store_buffer_pkg::store_entry_t mem_q [DEPTH_COMMIT];
  store_buffer_pkg::store_entry_t head;

  logic [DEPTH_COMMIT-1:0] valid_q, valid_d;

  logic [PTR_W-1:0] rd_ptr_q, rd_ptr_d;
  logic [PTR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [CNT_W-1:0] cnt_q, cnt_d;

  // request and pop qualifiers
  logic req;
  logic pop;

  assign head = mem_q[rd_ptr_q];

  // --------------------
  // cache request
  // --------------------
  // stall masks the request without touching the queue
  assign req = valid_q[rd_ptr_q] && !stall_st_pending_i;
  // head leaves at the edge that ends the granted cycle
  assign pop = req && data_gnt_i;

  // address splits into page index and tag
  assign dcache_wreq_o.data_req      = req;
  assign dcache_wreq_o.address_index =
    head.address[store_buffer_pkg::DCACHE_INDEX_WIDTH-1:0];
  assign dcache_wreq_o.address_tag   =
    head.address[store_buffer_pkg::DCACHE_TAG_WIDTH +
                 store_buffer_pkg::DCACHE_INDEX_WIDTH - 1 :
                 store_buffer_pkg::DCACHE_INDEX_WIDTH];
  assign dcache_wreq_o.data_wdata    = head.data;
  assign dcache_wreq_o.data_be       = head.be;
  assign dcache_wreq_o.data_size     = head.data_size;

  // --------------------
  // next-state logic
  // --------------------
  always_comb begin
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    valid_d  = valid_q;

    // granted head is retired
    if (pop) begin
      valid_d[rd_ptr_q] = 1'b0;
      rd_ptr_d          = rd_ptr_q + PTR_W'(1);
    end

    // spec head appended at the tail
    if (commit_i) begin
      valid_d[wr_ptr_q] = 1'b1;
      wr_ptr_d          = wr_ptr_q + PTR_W'(1);
    end

    // push and pop together leave the count alone
    case ({commit_i, pop})
      2'b10:   cnt_d = cnt_q + CNT_W'(1);
      2'b01:   cnt_d = cnt_q - CNT_W'(1);
      default: cnt_d = cnt_q;
    endcase
  end

  // status from registered count only
  assign commit_ready_o  = (cnt_q < CNT_MAX);
  assign no_st_pending_o = (cnt_q == '0);

  // --------------------
  // checker taps
  // --------------------
  assign slot_valid_o = valid_q;

  for (genvar i = 0; i < DEPTH_COMMIT; i++) begin : g_slot
    assign slot_offset_o[i] = mem_q[i].address[11:3];
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q  <= valid_d;
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      cnt_q    <= cnt_d;
    end
  end

  // payload copied from the spec head on commit
  always_ff @(posedge clk_i) begin
    if (commit_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

// File: hw/page_offset_checker.sv
`timescale 1ns/1ps

module page_offset_checker #(
  parameter int unsigned DEPTH_SPEC   = 4,
  parameter int unsigned DEPTH_COMMIT = 4
) (
  input  store_buffer_pkg::page_offset_t                    page_offset_i,
  input  store_buffer_pkg::paddr_t                          paddr_i,
  input  logic                                              valid_without_flush_i,
  input  logic [DEPTH_SPEC-1:0]                             spec_valid_i,
  input  store_buffer_pkg::word_offset_t [DEPTH_SPEC-1:0]   spec_offset_i,
  input  logic [DEPTH_COMMIT-1:0]                           commit_valid_i,
  input  store_buffer_pkg::word_offset_t [DEPTH_COMMIT-1:0] commit_offset_i,
  output logic                                              page_offset_matches_o
);

  // word of the load within its page
  store_buffer_pkg::word_offset_t load_word;
  // word of the store currently arriving
  store_buffer_pkg::word_offset_t inflight_word;

  assign load_word     = page_offset_i[11:3];
  assign inflight_word = paddr_i[11:3];

  // any hit means the load must wait for the buffer to drain
  always_comb begin
    page_offset_matches_o = 1'b0;

    // non-speculative stores
    for (int unsigned i = 0; i < DEPTH_COMMIT; i++) begin
      if (commit_valid_i[i] && (commit_offset_i[i] == load_word)) begin
        page_offset_matches_o = 1'b1;
      end
    end

    // speculative stores
    for (int unsigned i = 0; i < DEPTH_SPEC; i++) begin
      if (spec_valid_i[i] && (spec_offset_i[i] == load_word)) begin
        page_offset_matches_o = 1'b1;
      end
    end

    // store on the input port this cycle, not yet buffered
    if (valid_without_flush_i && (inflight_word == load_word)) begin
      page_offset_matches_o = 1'b1;
    end
  end

endmodule

// File: hw/store_buffer.sv
`timescale 1ns/1ps

module store_buffer #(
  // both depths must be powers of two, at least 2
  parameter int unsigned DEPTH_SPEC   = 4,
  parameter int unsigned DEPTH_COMMIT = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           stall_st_pending_i,
  input  logic                           valid_i,
  input  logic                           valid_without_flush_i,
  input  logic                           commit_i,
  input  logic                           data_gnt_i,
  input  store_buffer_pkg::paddr_t       paddr_i,
  input  store_buffer_pkg::data_t        data_i,
  input  store_buffer_pkg::be_t          be_i,
  input  store_buffer_pkg::size_t        size_i,
  input  store_buffer_pkg::page_offset_t page_offset_i,
  output logic                           ready_o,
  output logic                           commit_ready_o,
  output logic                           no_st_pending_o,
  output logic                           store_buffer_empty_o,
  output logic                           page_offset_matches_o,
  output store_buffer_pkg::dcache_wreq_t dcache_wreq_o
);

  // incoming store bundled for the spec queue
  store_buffer_pkg::store_entry_t st_entry;
  // spec head on its way to the commit queue
  store_buffer_pkg::store_entry_t spec_head;
  logic                           spec_empty;

  // per-slot checker taps
  logic [DEPTH_SPEC-1:0]                             spec_valid;
  store_buffer_pkg::word_offset_t [DEPTH_SPEC-1:0]   spec_offset;
  logic [DEPTH_COMMIT-1:0]                           commit_valid;
  store_buffer_pkg::word_offset_t [DEPTH_COMMIT-1:0] commit_offset;

  assign st_entry.address   = paddr_i;
  assign st_entry.data      = data_i;
  assign st_entry.be        = be_i;
  assign st_entry.data_size = size_i;

  // --------------------
  // speculative stage
  // --------------------
  spec_queue #(
    .DEPTH_SPEC (DEPTH_SPEC)
  ) u_spec_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .valid_i       (valid_i),
    .commit_i      (commit_i),
    .entry_i       (st_entry),
    .ready_o       (ready_o),
    .empty_o       (spec_empty),
    .head_o        (spec_head),
    .slot_valid_o  (spec_valid),
    .slot_offset_o (spec_offset)
  );

  // --------------------
  // commit stage
  // --------------------
  // flush never reaches here, committed stores always drain
  commit_queue #(
    .DEPTH_COMMIT (DEPTH_COMMIT)
  ) u_commit_queue (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .stall_st_pending_i (stall_st_pending_i),
    .commit_i           (commit_i),
    .data_gnt_i         (data_gnt_i),
    .entry_i            (spec_head),
    .commit_ready_o     (commit_ready_o),
    .no_st_pending_o    (no_st_pending_o),
    .dcache_wreq_o      (dcache_wreq_o),
    .slot_valid_o       (commit_valid),
    .slot_offset_o      (commit_offset)
  );

  // load-store word overlap
  page_offset_checker #(
    .DEPTH_SPEC   (DEPTH_SPEC),
    .DEPTH_COMMIT (DEPTH_COMMIT)
  ) u_page_offset_checker (
    .page_offset_i         (page_offset_i),
    .paddr_i               (paddr_i),
    .valid_without_flush_i (valid_without_flush_i),
    .spec_valid_i          (spec_valid),
    .spec_offset_i         (spec_offset),
    .commit_valid_i        (commit_valid),
    .commit_offset_i       (commit_offset),
    .page_offset_matches_o (page_offset_matches_o)
  );

  // nothing speculative and nothing waiting for the cache
  assign store_buffer_empty_o = spec_empty & no_st_pending_o;

endmodule

// File: tests/store_buffer_props.sv
`timescale 1ns/1ps

module store_buffer_props (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           flush_i,
  input logic                           commit_i,
  input logic                           valid_i,
  input logic                           ready_o,
  input logic                           commit_ready_o,
  input logic                           stall_st_pending_i,
  input logic                           data_gnt_i,
  input store_buffer_pkg::dcache_wreq_t dcache_wreq_o
);

  // failures so far, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // flush and commit are exclusive
  a_flush_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flush_i && commit_i))
    else begin
      fail_cnt++;
      $error("flush and commit in the same cycle");
    end

  // ready_o already counts the push of its own cycle
  // so a push needs room reported one cycle earlier
  a_push_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> $past(ready_o))
    else begin
      fail_cnt++;
      $error("store pushed without room");
    end

  a_commit_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    commit_i |-> commit_ready_o)
    else begin
      fail_cnt++;
      $error("commit while commit_ready_o low");
    end

  // ungranted request holds, unless stall masks it
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dcache_wreq_o.data_req && !data_gnt_i && !stall_st_pending_i) |=>
    (stall_st_pending_i || (dcache_wreq_o.data_req && $stable(dcache_wreq_o))))
    else begin
      fail_cnt++;
      $error("cache request dropped or changed before grant");
    end

endmodule

// File: tests/tb_store_buffer.sv
`timescale 1ns/1ps

module tb_store_buffer;

  localparam int unsigned DEPTH_SPEC   = 4;
  localparam int unsigned DEPTH_COMMIT = 4;
  // cycles a single wait may take
  localparam int unsigned TIMEOUT = 50;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           flush_i;
  logic                           stall_st_pending_i;
  logic                           valid_i;
  logic                           valid_without_flush_i;
  logic                           commit_i;
  logic                           data_gnt_i;
  store_buffer_pkg::paddr_t       paddr_i;
  store_buffer_pkg::data_t        data_i;
  store_buffer_pkg::be_t          be_i;
  store_buffer_pkg::size_t        size_i;
  store_buffer_pkg::page_offset_t page_offset_i;
  logic                           ready_o;
  logic                           commit_ready_o;
  logic                           no_st_pending_o;
  logic                           store_buffer_empty_o;
  logic                           page_offset_matches_o;
  store_buffer_pkg::dcache_wreq_t dcache_wreq_o;

  // model: stores still speculative, stores owed to the cache in order
  store_buffer_pkg::store_entry_t spec_q[$];
  store_buffer_pkg::store_entry_t cache_q[$];

  store_buffer #(
    .DEPTH_SPEC   (DEPTH_SPEC),
    .DEPTH_COMMIT (DEPTH_COMMIT)
  ) u_dut (.*);

  bind store_buffer store_buffer_props u_props (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i), .commit_i (commit_i),
    .valid_i (valid_i), .ready_o (ready_o), .commit_ready_o (commit_ready_o),
    .stall_st_pending_i (stall_st_pending_i), .data_gnt_i (data_gnt_i),
    .dcache_wreq_o (dcache_wreq_o)
  );

  always #50 clk_i = ~clk_i;

  // --------------------
  // reporting
  // --------------------
  task automatic stop_run();
    $display("Checks failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic value_error(input string name, input string exp_s, input string act_s);
    $display("[ERROR] %s expected %s actual %s", name, exp_s, act_s);
    stop_run();
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_error(name, $sformatf("%b", exp), $sformatf("%b", act));
    end
  endtask

  task automatic check_entry(input string name, input store_buffer_pkg::store_entry_t exp,
                             input store_buffer_pkg::store_entry_t act);
    if (act !== exp) begin
      value_error(name, $sformatf("%h", exp), $sformatf("%h", act));
    end
  endtask

  task automatic check_req(input string name, input store_buffer_pkg::dcache_wreq_t exp,
                           input store_buffer_pkg::dcache_wreq_t act);
    check_bit({name, " data_req"}, exp.data_req, act.data_req);
    if (act.address_index !== exp.address_index) begin
      value_error({name, " index"}, $sformatf("%h", exp.address_index),
                  $sformatf("%h", act.address_index));
    end
    if (act.address_tag !== exp.address_tag) begin
      value_error({name, " tag"}, $sformatf("%h", exp.address_tag),
                  $sformatf("%h", act.address_tag));
    end
    if (act.data_wdata !== exp.data_wdata) begin
      value_error({name, " wdata"}, $sformatf("%h", exp.data_wdata),
                  $sformatf("%h", act.data_wdata));
    end
    if (act.data_be !== exp.data_be) begin
      value_error({name, " be"}, $sformatf("%h", exp.data_be), $sformatf("%h", act.data_be));
    end
    if (act.data_size !== exp.data_size) begin
      value_error({name, " size"}, $sformatf("%h", exp.data_size),
                  $sformatf("%h", act.data_size));
    end
  endtask

  // --------------------
  // stimulus helpers
  // --------------------
  function automatic store_buffer_pkg::paddr_t rand_addr();
    return {2'($urandom_range(3)), $urandom};
  endfunction

  function automatic store_buffer_pkg::store_entry_t rand_entry(
      input store_buffer_pkg::paddr_t addr);
    store_buffer_pkg::store_entry_t e;
    e.address   = addr;
    e.data      = {$urandom, $urandom};
    e.be        = 8'($urandom);
    e.data_size = 2'($urandom);
    return e;
  endfunction

  // index is the low 12 address bits, tag the 22 above
  function automatic store_buffer_pkg::dcache_wreq_t make_req(
      input store_buffer_pkg::store_entry_t e);
    store_buffer_pkg::dcache_wreq_t r;
    r.data_req      = 1'b1;
    r.address_index = e.address[11:0];
    r.address_tag   = e.address[33:12];
    r.data_wdata    = e.data;
    r.data_be       = e.be;
    r.data_size     = e.data_size;
    return r;
  endfunction

  task automatic push_store(input store_buffer_pkg::store_entry_t e);
    @(negedge clk_i);
    paddr_i = e.address;
    data_i  = e.data;
    be_i    = e.be;
    size_i  = e.data_size;
    valid_i = 1'b1;
    spec_q.push_back(e);
    @(negedge clk_i);
    valid_i = 1'b0;
  endtask

  task automatic commit_store();
    @(negedge clk_i);
    commit_i = 1'b1;
    cache_q.push_back(spec_q.pop_front());
    @(negedge clk_i);
    commit_i = 1'b0;
  endtask

  // waits for the oldest owed store at the cache port and grants it
  task automatic drain_one(input string name, input logic use_stall);
    store_buffer_pkg::store_entry_t exp_e;
    store_buffer_pkg::store_entry_t act_e;
    int unsigned waited;
    logic granted;
    exp_e   = cache_q.pop_front();
    waited  = 0;
    granted = 1'b0;
    while (!granted) begin
      if (waited == TIMEOUT) begin
        $display("%s: no granted cache request within %0d cycles", name, TIMEOUT);
        stop_run();
      end
      waited++;
      @(negedge clk_i);
      // random stall pulses and late grants
      stall_st_pending_i = use_stall && ($urandom_range(3) == 0);
      data_gnt_i         = ($urandom_range(2) == 0);
      #1;
      if (stall_st_pending_i) begin
        check_bit({name, " req under stall"}, 1'b0, dcache_wreq_o.data_req);
      end else if (dcache_wreq_o.data_req) begin
        act_e = {dcache_wreq_o.address_tag, dcache_wreq_o.address_index,
                 dcache_wreq_o.data_wdata, dcache_wreq_o.data_be, dcache_wreq_o.data_size};
        check_entry(name, exp_e, act_e);
        granted = data_gnt_i;
      end
    end
    @(negedge clk_i);
    data_gnt_i         = 1'b0;
    stall_st_pending_i = 1'b0;
  endtask

  task automatic probe(input string name, input store_buffer_pkg::paddr_t addr,
                       input store_buffer_pkg::page_offset_t offset, input logic inflight,
                       input logic exp);
    @(negedge clk_i);
    paddr_i               = addr;
    page_offset_i         = offset;
    valid_without_flush_i = inflight;
    #1;
    check_bit(name, exp, page_offset_matches_o);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_reset_values();
    #1;
    check_bit("reset data_req", 1'b0, dcache_wreq_o.data_req);
    check_bit("reset ready", 1'b1, ready_o);
    check_bit("reset commit_ready", 1'b1, commit_ready_o);
    check_bit("reset no_st_pending", 1'b1, no_st_pending_o);
    check_bit("reset empty", 1'b1, store_buffer_empty_o);
    check_bit("reset match", 1'b0, page_offset_matches_o);
  endtask

  task automatic test_single_store();
    store_buffer_pkg::store_entry_t e;
    e = rand_entry(34'h2_ABCD_E5F8);
    push_store(e);
    commit_store();
    // request is up in the cycle after the commit edge
    #1;
    check_req("single_store", make_req(e), dcache_wreq_o);
    check_bit("single_store empty", 1'b0, store_buffer_empty_o);
    drain_one("single_store", 1'b0);
    #1;
    check_bit("single_store no_st_pending", 1'b1, no_st_pending_o);
    check_bit("single_store empty after", 1'b1, store_buffer_empty_o);
  endtask

  task automatic test_ordering();
    repeat (2) begin
      repeat (3) push_store(rand_entry(rand_addr()));
      repeat (3) commit_store();
      repeat (3) drain_one("ordering", 1'b1);
    end
  endtask

  task automatic test_flush();
    store_buffer_pkg::store_entry_t dropped;
    store_buffer_pkg::store_entry_t fresh;
    repeat (2) push_store(rand_entry(rand_addr()));
    dropped = rand_entry(rand_addr());
    push_store(dropped);
    commit_store();
    @(negedge clk_i);
    flush_i = 1'b1;
    spec_q.delete();
    @(negedge clk_i);
    flush_i = 1'b0;
    drain_one("flush", 1'b0);
    #1;
    check_bit("flush empty", 1'b1, store_buffer_empty_o);
    // flushed slots no longer count for the load check
    probe("flush dropped match", '0, dropped.address[11:0], 1'b0, 1'b0);
    // next commit must carry the new store, not a flushed one
    fresh = rand_entry(rand_addr());
    push_store(fresh);
    commit_store();
    drain_one("flush next store", 1'b0);
    // flushed stores never show up
    repeat (8) begin
      @(negedge clk_i);
      #1;
      check_bit("flush extra req", 1'b0, dcache_wreq_o.data_req);
    end
    check_bit("flush empty after", 1'b1, store_buffer_empty_o);
  endtask

  task automatic test_match();
    store_buffer_pkg::store_entry_t a;
    a = rand_entry(34'h1_0000_0A48);
    push_store(a);
    probe("match spec", a.address, 12'hA4D, 1'b0, 1'b1);
    probe("match other word", a.address, 12'hA50, 1'b0, 1'b0);
    commit_store();
    probe("match commit", a.address, 12'hA48, 1'b0, 1'b1);
    probe("match inflight", 34'h2_0000_0C10, 12'hC17, 1'b1, 1'b1);
    probe("match no inflight", 34'h2_0000_0C10, 12'hC17, 1'b0, 1'b0);
    drain_one("match", 1'b0);
    probe("match drained", a.address, 12'hA48, 1'b0, 1'b0);
  endtask

  task automatic test_full();
    repeat (DEPTH_SPEC) push_store(rand_entry(rand_addr()));
    #1;
    check_bit("full ready", 1'b0, ready_o);
    @(negedge clk_i);
    commit_i = 1'b1;
    cache_q.push_back(spec_q.pop_front());
    #1;
    check_bit("full ready with commit", 1'b1, ready_o);
    @(negedge clk_i);
    commit_i           = 1'b0;
    stall_st_pending_i = 1'b1;
    repeat (DEPTH_COMMIT - 1) commit_store();
    #1;
    check_bit("full commit_ready", 1'b0, commit_ready_o);
    check_bit("full req under stall", 1'b0, dcache_wreq_o.data_req);
    repeat (DEPTH_COMMIT) drain_one("full", 1'b0);
    #1;
    check_bit("full empty after", 1'b1, store_buffer_empty_o);
  endtask

  initial begin
    void'($urandom(62));
    clk_i                 = 1'b0;
    rst_ni                = 1'b0;
    flush_i               = 1'b0;
    stall_st_pending_i    = 1'b0;
    valid_i               = 1'b0;
    valid_without_flush_i = 1'b0;
    commit_i              = 1'b0;
    data_gnt_i            = 1'b0;
    paddr_i               = '0;
    data_i                = '0;
    be_i                  = '0;
    size_i                = '0;
    page_offset_i         = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    test_reset_values();
    test_single_store();
    test_ordering();
    test_flush();
    test_match();
    test_full();
    if (u_dut.u_props.fail_cnt != 0) begin
      $display("%0d bound assertion failures", u_dut.u_props.fail_cnt);
      stop_run();
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: project.f
hw/store_buffer_pkg.sv
hw/spec_queue.sv
hw/commit_queue.sv
hw/page_offset_checker.sv
hw/store_buffer.sv
tests/store_buffer_props.sv
tests/tb_store_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the store buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_store_buffer -f project.f -o sim_store_buffer \
  || { echo "build failed"; exit 1; }

# assertion failures are counted by the testbench, so let the run continue
./obj_dir/sim_store_buffer +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

! grep -q "Checks failed" sim.log && grep -q "All checks passed" sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation FAILED"; exit 1; }
